//--- hdl/issue_pkg.sv
/*
 * Shared sizes and field types of the two-warp SIMT issue stage.
 * Imported by every module that carries instruction fields or counts entries.
 */
package issue_pkg;

    // ########################################################################
    // Sizes
    // ########################################################################

    // Warps sharing one dispatch port
    localparam int unsigned NUM_WARPS    = 2;
    // Wait-buffer slots per warp
    localparam int unsigned WB_DEPTH     = 4;
    // Source operands per instruction
    localparam int unsigned NUM_OPERANDS = 2;
    // Result tags that can be in flight
    localparam int unsigned NUM_TAGS     = 8;

    // Field widths
    localparam int unsigned PC_W       = 32;
    localparam int unsigned ACT_MASK_W = 32;
    localparam int unsigned REG_IDX_W  = 6;
    localparam int unsigned TAG_W      = $clog2(NUM_TAGS);
    localparam int unsigned WARP_IDX_W = $clog2(NUM_WARPS);
    localparam int unsigned WB_IDX_W   = $clog2(WB_DEPTH);

    // Credit count must reach WB_DEPTH itself
    localparam int unsigned CREDIT_W   = $clog2(WB_DEPTH + 1);

    // ########################################################################
    // Field types
    // ########################################################################

    typedef logic [PC_W-1:0]       pc_t;
    typedef logic [ACT_MASK_W-1:0] act_mask_t;
    typedef logic [TAG_W-1:0]      tag_t;
    typedef logic [REG_IDX_W-1:0]  reg_idx_t;
    typedef logic [WARP_IDX_W-1:0] warp_idx_t;
    typedef logic [WB_IDX_W-1:0]   wb_idx_t;

endpackage

//--- hdl/credit_counter.sv
/*
 * Free-slot counter of one warp's wait buffer.
 * Fetch takes a credit, dispatch gives one back; the fetcher sees a nonzero flag.
 */
`timescale 1ns/10ps

module credit_counter
    import issue_pkg::*;
(
    input  logic clk_i,
    input  logic arst_n_i,
    input  logic credit_take_i,
    input  logic credit_give_i,
    output logic credit_left_o
);

    // Number of free slots not yet promised to the fetcher
    logic [CREDIT_W-1:0] count_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            // All slots free after reset
            count_q <= CREDIT_W'(WB_DEPTH);
        end else if (credit_take_i && !credit_give_i) begin
            count_q <= count_q - 1'b1;
        end else if (credit_give_i && !credit_take_i) begin
            count_q <= count_q + 1'b1;
        end
        // Take and give together cancel out
    end

    // Fetcher may send another instruction
    assign credit_left_o = (count_q != '0);

endmodule

//--- hdl/rr_arbiter.sv
/*
 * Fair round-robin arbiter with a valid/ready output side.
 * The choice is held under back-pressure; the grant fires on an accepted transfer.
 */
`timescale 1ns/10ps

module rr_arbiter #(
    parameter int unsigned NUM_REQ = 4
) (
    input  logic                       clk_i,
    input  logic                       arst_n_i,
    input  logic [NUM_REQ-1:0]         req_i,
    input  logic                       ready_i,
    output logic                       valid_o,
    output logic [NUM_REQ-1:0]         gnt_o,
    output logic [$clog2(NUM_REQ)-1:0] idx_o
);

    localparam int unsigned IDX_W = $clog2(NUM_REQ);

    // Requester with the highest priority next round
    logic [IDX_W-1:0] ptr_q;
    // Held choice while the consumer stalls
    logic             lock_q;
    logic [IDX_W-1:0] lock_idx_q;
    // Fresh choice from the pointer
    logic [IDX_W-1:0] pick_idx;
    logic             xfer;

    // ########################################################################
    // Choice
    // ########################################################################

    // First request at or after the pointer, wrapping around
    always_comb begin
        int  cand;
        logic found;
        pick_idx = '0;
        found    = 1'b0;
        for (int i = 0; i < NUM_REQ; i++) begin
            cand = (int'(ptr_q) + i) % NUM_REQ;
            if (!found && req_i[cand]) begin
                pick_idx = IDX_W'(cand);
                found    = 1'b1;
            end
        end
    end

    // Requests never drop before their grant, so a held index stays requested
    assign valid_o = |req_i;
    assign idx_o   = lock_q ? lock_idx_q : pick_idx;
    assign xfer    = valid_o && ready_i;

    // One-hot grant only when the transfer completes
    always_comb begin
        gnt_o = '0;
        if (xfer) begin
            gnt_o[idx_o] = 1'b1;
        end
    end

    // ########################################################################
    // State
    // ########################################################################

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ptr_q      <= '0;
            lock_q     <= 1'b0;
            lock_idx_q <= '0;
        end else begin
            // Stall keeps the current choice for the next cycle
            lock_q     <= valid_o && !ready_i;
            lock_idx_q <= idx_o;
            // Winner drops to lowest priority
            if (xfer) begin
                ptr_q <= (idx_o == IDX_W'(NUM_REQ - 1)) ? '0 : idx_o + 1'b1;
            end
        end
    end

endmodule

//--- hdl/wait_buffer.sv
/*
 * Per-warp buffer of decoded instructions waiting for their source tags.
 * Woken entries are offered round-robin on a valid/ready dispatch port.
 */
`timescale 1ns/10ps

module wait_buffer
    import issue_pkg::*;
(
    input  logic                            clk_i,
    input  logic                            arst_n_i,
    // Fetcher
    input  logic                            fe_handshake_i,
    output logic                            ib_space_available_o,
    // Decoder
    output logic                            wb_ready_o,
    input  logic                            dec_valid_i,
    input  pc_t                             dec_pc_i,
    input  act_mask_t                       dec_act_mask_i,
    input  tag_t                            dec_tag_i,
    input  reg_idx_t                        dec_dst_reg_i,
    input  logic     [NUM_OPERANDS-1:0]     dec_operands_ready_i,
    input  tag_t     [NUM_OPERANDS-1:0]     dec_operand_tags_i,
    input  reg_idx_t [NUM_OPERANDS-1:0]     dec_operands_i,
    // Execution units
    input  logic                            eu_valid_i,
    input  tag_t                            eu_tag_i,
    // Operand collector
    input  logic                            opc_ready_i,
    output logic                            disp_valid_o,
    output tag_t                            disp_tag_o,
    output pc_t                             disp_pc_o,
    output act_mask_t                       disp_act_mask_o,
    output reg_idx_t                        disp_dst_o,
    output reg_idx_t [NUM_OPERANDS-1:0]     disp_operands_o
);

    // ########################################################################
    // Entry storage
    // ########################################################################

    logic [WB_DEPTH-1:0]                valid_q;
    pc_t                                pc_q       [WB_DEPTH];
    act_mask_t                          act_mask_q [WB_DEPTH];
    tag_t                               tag_q      [WB_DEPTH];
    reg_idx_t                           dst_q      [WB_DEPTH];
    logic     [NUM_OPERANDS-1:0]        opnd_rdy_q [WB_DEPTH];
    tag_t     [NUM_OPERANDS-1:0]        opnd_tag_q [WB_DEPTH];
    reg_idx_t [NUM_OPERANDS-1:0]        opnd_reg_q [WB_DEPTH];

    logic    [WB_DEPTH-1:0]             inst_ready;
    logic    [WB_DEPTH-1:0]             arb_gnt;
    wb_idx_t                            arb_idx;
    wb_idx_t                            ins_idx;
    logic                               ins_en;

    // Free-slot credits towards the fetcher
    credit_counter i_credit_counter (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .credit_take_i (fe_handshake_i),
        .credit_give_i (|arb_gnt),
        .credit_left_o (ib_space_available_o)
    );

    // Room while any slot is free
    assign wb_ready_o = ~&valid_q;
    assign ins_en     = dec_valid_i && wb_ready_o;

    // Lowest free slot takes the next instruction
    always_comb begin
        ins_idx = '0;
        for (int e = WB_DEPTH - 1; e >= 0; e--) begin
            if (!valid_q[e]) begin
                ins_idx = wb_idx_t'(e);
            end
        end
    end

    // ########################################################################
    // Entry update
    // ########################################################################

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
        end else begin
            for (int e = 0; e < WB_DEPTH; e++) begin
                // Insert targets a free slot, grant a used one
                if (ins_en && ins_idx == wb_idx_t'(e)) begin
                    valid_q[e] <= 1'b1;
                end else if (arb_gnt[e]) begin
                    valid_q[e] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        for (int e = 0; e < WB_DEPTH; e++) begin
            if (ins_en && ins_idx == wb_idx_t'(e)) begin
                pc_q[e]       <= dec_pc_i;
                act_mask_q[e] <= dec_act_mask_i;
                tag_q[e]      <= dec_tag_i;
                dst_q[e]      <= dec_dst_reg_i;
                opnd_rdy_q[e] <= dec_operands_ready_i;
                opnd_tag_q[e] <= dec_operand_tags_i;
                opnd_reg_q[e] <= dec_operands_i;
            end else if (eu_valid_i && valid_q[e]) begin
                // Wakeup of operands waiting on the broadcast tag
                for (int o = 0; o < NUM_OPERANDS; o++) begin
                    if (!opnd_rdy_q[e][o] && opnd_tag_q[e][o] == eu_tag_i) begin
                        opnd_rdy_q[e][o] <= 1'b1;
                    end
                end
            end
        end
    end

    // ########################################################################
    // Dispatch
    // ########################################################################

    // Valid with every source available
    always_comb begin
        for (int e = 0; e < WB_DEPTH; e++) begin
            inst_ready[e] = valid_q[e] && (&opnd_rdy_q[e]);
        end
    end

    rr_arbiter #(
        .NUM_REQ (WB_DEPTH)
    ) i_entry_arb (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .req_i    (inst_ready),
        .ready_i  (opc_ready_i),
        .valid_o  (disp_valid_o),
        .gnt_o    (arb_gnt),
        .idx_o    (arb_idx)
    );

    // Fields straight from the chosen registered entry
    assign disp_pc_o       = pc_q[arb_idx];
    assign disp_act_mask_o = act_mask_q[arb_idx];
    assign disp_tag_o      = tag_q[arb_idx];
    assign disp_dst_o      = dst_q[arb_idx];
    assign disp_operands_o = opnd_reg_q[arb_idx];

endmodule

//--- hdl/warp_issue_stage.sv
/*
 * Issue stage top for two warps sharing one operand-collector port.
 * Steers decoded instructions to their warp and arbitrates the warps for dispatch.
 */
`timescale 1ns/10ps

module warp_issue_stage
    import issue_pkg::*;
(
    input  logic                            clk_i,
    input  logic                            arst_n_i,
    // Fetcher
    input  logic     [NUM_WARPS-1:0]        fe_handshake_i,
    output logic     [NUM_WARPS-1:0]        ib_space_available_o,
    // Decoder
    output logic     [NUM_WARPS-1:0]        wb_ready_o,
    input  logic                            dec_valid_i,
    input  warp_idx_t                       dec_warp_i,
    input  pc_t                             dec_pc_i,
    input  act_mask_t                       dec_act_mask_i,
    input  tag_t                            dec_tag_i,
    input  reg_idx_t                        dec_dst_reg_i,
    input  logic     [NUM_OPERANDS-1:0]     dec_operands_ready_i,
    input  tag_t     [NUM_OPERANDS-1:0]     dec_operand_tags_i,
    input  reg_idx_t [NUM_OPERANDS-1:0]     dec_operands_i,
    // Execution units
    input  logic                            eu_valid_i,
    input  tag_t                            eu_tag_i,
    // Operand collector
    input  logic                            opc_ready_i,
    output logic                            disp_valid_o,
    output warp_idx_t                       disp_warp_o,
    output tag_t                            disp_tag_o,
    output pc_t                             disp_pc_o,
    output act_mask_t                       disp_act_mask_o,
    output reg_idx_t                        disp_dst_o,
    output reg_idx_t [NUM_OPERANDS-1:0]     disp_operands_o
);

    // Per-warp dispatch candidates
    logic     [NUM_WARPS-1:0]           wb_disp_valid;
    logic     [NUM_WARPS-1:0]           warp_gnt;
    warp_idx_t                          warp_idx;
    tag_t                               wb_tag      [NUM_WARPS];
    pc_t                                wb_pc       [NUM_WARPS];
    act_mask_t                          wb_act_mask [NUM_WARPS];
    reg_idx_t                           wb_dst      [NUM_WARPS];
    reg_idx_t [NUM_OPERANDS-1:0]        wb_operands [NUM_WARPS];

    // ########################################################################
    // Warp buffers
    // ########################################################################

    for (genvar w = 0; w < NUM_WARPS; w++) begin : gen_warp
        wait_buffer i_wait_buffer (
            .clk_i                (clk_i),
            .arst_n_i             (arst_n_i),
            .fe_handshake_i       (fe_handshake_i[w]),
            .ib_space_available_o (ib_space_available_o[w]),
            .wb_ready_o           (wb_ready_o[w]),
            // Strobe only for the addressed warp
            .dec_valid_i          (dec_valid_i && (dec_warp_i == warp_idx_t'(w))),
            .dec_pc_i             (dec_pc_i),
            .dec_act_mask_i       (dec_act_mask_i),
            .dec_tag_i            (dec_tag_i),
            .dec_dst_reg_i        (dec_dst_reg_i),
            .dec_operands_ready_i (dec_operands_ready_i),
            .dec_operand_tags_i   (dec_operand_tags_i),
            .dec_operands_i       (dec_operands_i),
            // Broadcast reaches every warp
            .eu_valid_i           (eu_valid_i),
            .eu_tag_i             (eu_tag_i),
            // Ready only for the warp that wins the port
            .opc_ready_i          (opc_ready_i && warp_gnt[w]),
            .disp_valid_o         (wb_disp_valid[w]),
            .disp_tag_o           (wb_tag[w]),
            .disp_pc_o            (wb_pc[w]),
            .disp_act_mask_o      (wb_act_mask[w]),
            .disp_dst_o           (wb_dst[w]),
            .disp_operands_o      (wb_operands[w])
        );
    end

    // ########################################################################
    // Warp arbitration
    // ########################################################################

    rr_arbiter #(
        .NUM_REQ (NUM_WARPS)
    ) i_warp_arb (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .req_i    (wb_disp_valid),
        .ready_i  (opc_ready_i),
        .valid_o  (disp_valid_o),
        .gnt_o    (warp_gnt),
        .idx_o    (warp_idx)
    );

    // Winning warp drives the shared port
    assign disp_warp_o     = warp_idx;
    assign disp_tag_o      = wb_tag[warp_idx];
    assign disp_pc_o       = wb_pc[warp_idx];
    assign disp_act_mask_o = wb_act_mask[warp_idx];
    assign disp_dst_o      = wb_dst[warp_idx];
    assign disp_operands_o = wb_operands[warp_idx];

endmodule

//--- verification/tb_warp_issue_stage.sv
/*
 * Directed testbench of the two-warp issue stage, with a model queue of
 * inserted instructions. Run from the project root with all.f.
 */
`timescale 1ns/10ps

module tb_warp_issue_stage
    import issue_pkg::*;
;

    localparam int unsigned TIMEOUT = 50;
    // Packed instruction record {warp, pc, mask, tag, dst, operands}
    localparam int unsigned REC_W = WARP_IDX_W + PC_W + ACT_MASK_W + TAG_W
                                  + REG_IDX_W * (NUM_OPERANDS + 1);
    typedef logic [REC_W-1:0] rec_t;

    logic                        clk_i;
    logic                        arst_n_i;
    logic [NUM_WARPS-1:0]        fe_handshake_i;
    logic [NUM_WARPS-1:0]        ib_space_available_o;
    logic [NUM_WARPS-1:0]        wb_ready_o;
    logic                        dec_valid_i;
    warp_idx_t                   dec_warp_i;
    pc_t                         dec_pc_i;
    act_mask_t                   dec_act_mask_i;
    tag_t                        dec_tag_i;
    reg_idx_t                    dec_dst_reg_i;
    logic [NUM_OPERANDS-1:0]     dec_operands_ready_i;
    tag_t [NUM_OPERANDS-1:0]     dec_operand_tags_i;
    reg_idx_t [NUM_OPERANDS-1:0] dec_operands_i;
    logic                        eu_valid_i;
    tag_t                        eu_tag_i;
    logic                        opc_ready_i;
    logic                        disp_valid_o;
    warp_idx_t                   disp_warp_o;
    tag_t                        disp_tag_o;
    pc_t                         disp_pc_o;
    act_mask_t                   disp_act_mask_o;
    reg_idx_t                    disp_dst_o;
    reg_idx_t [NUM_OPERANDS-1:0] disp_operands_o;

    // Instructions inserted but not yet dispatched
    rec_t        model_q[$];
    int unsigned error_count;
    int unsigned timeout_count;
    logic [31:0] rng_state;

    warp_issue_stage i_dut (.*);

    always #2 clk_i = ~clk_i;

    // ########################################################################
    // Helpers
    // ########################################################################

    function automatic logic [31:0] xorshift32_next(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic rec_t make_rec(input warp_idx_t w, input pc_t pc, input act_mask_t mask,
                                      input tag_t tag, input reg_idx_t dst,
                                      input reg_idx_t [NUM_OPERANDS-1:0] ops);
        return {w, pc, mask, tag, dst, ops};
    endfunction

    task automatic draw(output logic [31:0] r);
        rng_state = xorshift32_next(rng_state);
        r         = rng_state;
    endtask

    // Inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk_i);
        #1;
    endtask

    task automatic check_eq(input string name, input logic [127:0] exp, input logic [127:0] act);
        if (exp !== act) begin
            $display("Mismatch at %0t: %s expected %0h, got %0h", $time, name, exp, act);
            error_count++;
        end
    endtask

    // Per-field comparison of a dispatch with the expected instruction
    task automatic compare_inst(input rec_t exp, input rec_t got);
        warp_idx_t                   ew, gw;
        pc_t                         epc, gpc;
        act_mask_t                   emask, gmask;
        tag_t                        etag, gtag;
        reg_idx_t                    edst, gdst;
        reg_idx_t [NUM_OPERANDS-1:0] eops, gops;
        {ew, epc, emask, etag, edst, eops} = exp;
        {gw, gpc, gmask, gtag, gdst, gops} = got;
        check_eq("disp_warp_o", ew, gw);
        check_eq("disp_pc_o", epc, gpc);
        check_eq("disp_act_mask_o", emask, gmask);
        check_eq("disp_tag_o", etag, gtag);
        check_eq("disp_dst_o", edst, gdst);
        check_eq("disp_operands_o", eops, gops);
    endtask

    // Removes one matching record from the model, in any order
    task automatic retire(input rec_t got);
        int idx;
        idx = -1;
        for (int i = 0; i < model_q.size(); i++) begin
            if (idx < 0 && model_q[i] === got) begin
                idx = i;
            end
        end
        if (idx < 0) begin
            $display("%0t: dispatched instruction %0h was never inserted or came twice",
                     $time, got);
            error_count++;
        end else begin
            model_q.delete(idx);
        end
    endtask

    // ########################################################################
    // Bus tasks
    // ########################################################################

    task automatic fetch(input warp_idx_t w);
        fe_handshake_i[w] = 1'b1;
        next_cycle();
        fe_handshake_i = '0;
    endtask

    task automatic broadcast(input tag_t t);
        eu_valid_i = 1'b1;
        eu_tag_i   = t;
        next_cycle();
        eu_valid_i = 1'b0;
    endtask

    // Decoder insert, optionally with the fetch pulse of the same instruction
    task automatic insert(input warp_idx_t w, input pc_t pc, input act_mask_t mask,
                          input tag_t tag, input reg_idx_t dst,
                          input logic [NUM_OPERANDS-1:0] rdy,
                          input tag_t [NUM_OPERANDS-1:0] otags,
                          input reg_idx_t [NUM_OPERANDS-1:0] ops, input logic with_fetch);
        int unsigned n;
        n = 0;
        while (!wb_ready_o[w] && n < TIMEOUT) begin
            next_cycle();
            n++;
        end
        if (!wb_ready_o[w]) begin
            $display("%0t: timeout waiting for wb_ready_o of warp %0d", $time, w);
            timeout_count++;
        end else begin
            dec_valid_i          = 1'b1;
            dec_warp_i           = w;
            dec_pc_i             = pc;
            dec_act_mask_i       = mask;
            dec_tag_i            = tag;
            dec_dst_reg_i        = dst;
            dec_operands_ready_i = rdy;
            dec_operand_tags_i   = otags;
            dec_operands_i       = ops;
            fe_handshake_i[w]    = with_fetch;
            model_q.push_back(make_rec(w, pc, mask, tag, dst, ops));
            next_cycle();
            dec_valid_i    = 1'b0;
            fe_handshake_i = '0;
        end
    endtask

    // Raises opc_ready_i, waits for one transfer and returns its fields
    task automatic expect_dispatch(output rec_t got, output logic ok, output int unsigned n);
        opc_ready_i = 1'b1;
        ok          = 1'b0;
        got         = '0;
        n           = 0;
        @(negedge clk_i);
        while (!disp_valid_o && n < TIMEOUT) begin
            @(negedge clk_i);
            n++;
        end
        if (!disp_valid_o) begin
            $display("%0t: timeout waiting for disp_valid_o", $time);
            timeout_count++;
        end else begin
            got = make_rec(disp_warp_o, disp_pc_o, disp_act_mask_o, disp_tag_o,
                           disp_dst_o, disp_operands_o);
            ok  = 1'b1;
            retire(got);
        end
        next_cycle();
        opc_ready_i = 1'b0;
    endtask

    // ########################################################################
    // Tests
    // ########################################################################

    task automatic test_reset_state();
        @(negedge clk_i);
        check_eq("ib_space_available_o", 2'b11, ib_space_available_o);
        check_eq("wb_ready_o", 2'b11, wb_ready_o);
        check_eq("disp_valid_o", 1'b0, disp_valid_o);
        next_cycle();
    endtask

    // All operands ready, valid in the cycle after the insert edge
    task automatic test_ready_latency();
        rec_t        got;
        logic        ok;
        int unsigned n;
        insert(1'b1, 32'h0000_1040, 32'hFFFF_0000, 3'd2, 6'd17, 2'b11, {3'd0, 3'd0},
               {6'd9, 6'd4}, 1'b1);
        expect_dispatch(got, ok, n);
        check_eq("dispatch latency in cycles", 0, n);
        if (ok) begin
            compare_inst(make_rec(1'b1, 32'h0000_1040, 32'hFFFF_0000, 3'd2, 6'd17,
                                  {6'd9, 6'd4}), got);
        end
    endtask

    task automatic test_wakeup();
        rec_t        got;
        logic        ok;
        int unsigned n;
        insert(1'b0, 32'h0000_2000, 32'h0000_00FF, 3'd7, 6'd33, 2'b00, {3'd5, 3'd3},
               {6'd12, 6'd40}, 1'b1);
        // Unrelated tag
        broadcast(3'd6);
        @(negedge clk_i);
        check_eq("disp_valid_o", 1'b0, disp_valid_o);
        next_cycle();
        // First source only
        broadcast(3'd3);
        for (int i = 0; i < 2; i++) begin
            @(negedge clk_i);
            check_eq("disp_valid_o", 1'b0, disp_valid_o);
            next_cycle();
        end
        broadcast(3'd5);
        expect_dispatch(got, ok, n);
        if (ok) begin
            compare_inst(make_rec(1'b0, 32'h0000_2000, 32'h0000_00FF, 3'd7, 6'd33,
                                  {6'd12, 6'd40}), got);
        end
    endtask

    task automatic test_credits();
        rec_t        got;
        logic        ok;
        int unsigned n;
        // Last credit gone after the fourth pulse
        for (int i = 0; i < WB_DEPTH; i++) begin
            fetch(1'b0);
            @(negedge clk_i);
            check_eq("ib_space_available_o[0]", (i < WB_DEPTH - 1), ib_space_available_o[0]);
            check_eq("ib_space_available_o[1]", 1'b1, ib_space_available_o[1]);
            next_cycle();
        end
        // Decoder delivers the four fetched instructions
        for (int i = 0; i < WB_DEPTH; i++) begin
            insert(1'b0, pc_t'(32'h3000 + 4 * i), 32'h1, tag_t'(i), reg_idx_t'(i), 2'b11,
                   {3'd0, 3'd0}, {reg_idx_t'(i + 1), reg_idx_t'(i + 2)}, 1'b0);
        end
        expect_dispatch(got, ok, n);
        @(negedge clk_i);
        check_eq("ib_space_available_o[0]", 1'b1, ib_space_available_o[0]);
        next_cycle();
        for (int i = 1; i < WB_DEPTH; i++) begin
            expect_dispatch(got, ok, n);
        end
    endtask

    task automatic test_backpressure_fairness();
        rec_t        first, got;
        logic        ok;
        int unsigned n;
        // Offer of the first instruction, warp 0
        first = make_rec(1'b0, 32'h0000_4000, 32'hA5A5_0000, 3'd4, 6'd20, {6'd0, 6'd63});
        // More instructions arrive while the collector stalls
        for (int i = 0; i < 4; i++) begin
            insert(warp_idx_t'(i % 2), pc_t'(32'h4000 + 8 * i), 32'hA5A5_0000 | i,
                   tag_t'(i + 4), reg_idx_t'(20 + i), 2'b11, {3'd0, 3'd0},
                   {reg_idx_t'(i), reg_idx_t'(63 - i)}, 1'b1);
            @(negedge clk_i);
            check_eq("disp_valid_o", 1'b1, disp_valid_o);
            check_eq("disp fields under stall", first,
                     make_rec(disp_warp_o, disp_pc_o, disp_act_mask_o, disp_tag_o,
                              disp_dst_o, disp_operands_o));
            next_cycle();
        end
        // A few idle stall cycles on top
        for (int i = 0; i < 2; i++) begin
            @(negedge clk_i);
            check_eq("disp_valid_o", 1'b1, disp_valid_o);
            check_eq("disp fields under stall", first,
                     make_rec(disp_warp_o, disp_pc_o, disp_act_mask_o, disp_tag_o,
                              disp_dst_o, disp_operands_o));
            next_cycle();
        end
        // Held warp 0 goes first, then the warps take turns
        for (int i = 0; i < 4; i++) begin
            expect_dispatch(got, ok, n);
            if (ok) begin
                check_eq("disp_warp_o", warp_idx_t'(i % 2), got[REC_W-1]);
            end
        end
    endtask

    // Random fill of both warps, then every tag, then a full drain
    task automatic test_random_traffic();
        int unsigned cnt [NUM_WARPS];
        logic [31:0] r0, r1, r2;
        warp_idx_t   w;
        rec_t        got;
        logic        ok;
        int unsigned n;
        cnt[0] = 0;
        cnt[1] = 0;
        for (int i = 0; i < NUM_WARPS * WB_DEPTH; i++) begin
            draw(r0);
            draw(r1);
            draw(r2);
            w = r0[31];
            if (cnt[w] == WB_DEPTH) begin
                w = ~w;
            end
            cnt[w]++;
            insert(w, r1, r2, r0[2:0], r0[8:3], r0[10:9], {r0[13:11], r0[16:14]},
                   {r0[22:17], r0[28:23]}, 1'b1);
        end
        for (int t = 0; t < NUM_TAGS; t++) begin
            broadcast(tag_t'(t));
        end
        for (int i = 0; i < NUM_WARPS * WB_DEPTH; i++) begin
            expect_dispatch(got, ok, n);
        end
        if (model_q.size() != 0) begin
            $display("%0t: %0d inserted instructions were never dispatched",
                     $time, model_q.size());
            error_count++;
        end
        @(negedge clk_i);
        check_eq("disp_valid_o", 1'b0, disp_valid_o);
        check_eq("ib_space_available_o", 2'b11, ib_space_available_o);
        next_cycle();
    endtask

    // ########################################################################
    // Sequence
    // ########################################################################

    initial begin
        clk_i                = 1'b0;
        arst_n_i             = 1'b0;
        fe_handshake_i       = '0;
        dec_valid_i          = 1'b0;
        dec_warp_i           = '0;
        dec_pc_i             = '0;
        dec_act_mask_i       = '0;
        dec_tag_i            = '0;
        dec_dst_reg_i        = '0;
        dec_operands_ready_i = '0;
        dec_operand_tags_i   = '0;
        dec_operands_i       = '0;
        eu_valid_i           = 1'b0;
        eu_tag_i             = '0;
        opc_ready_i          = 1'b0;
        error_count          = 0;
        timeout_count        = 0;
        rng_state            = 32'd56;
        repeat (4) @(posedge clk_i);
        #1;
        arst_n_i = 1'b1;

        test_reset_state();
        test_ready_latency();
        test_wakeup();
        test_credits();
        test_backpressure_fairness();
        test_random_traffic();

        $display("Errors: %0d, timeouts: %0d", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- all.f
hdl/issue_pkg.sv
hdl/credit_counter.sv
hdl/rr_arbiter.sv
hdl/wait_buffer.sv
hdl/warp_issue_stage.sv
verification/tb_warp_issue_stage.sv

//--- Makefile
# Verilator build and run of the issue-stage testbench

TOP := tb_warp_issue_stage

.PHONY: compile run clean

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f all.f -Mdir obj_dir -o sim

run: compile
	@out="$$(./obj_dir/sim)"; echo "$$out"; echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf obj_dir
